//--- logic/spike_gen_pkg.sv
package spike_gen_pkg;

  //////////////////////////////////////////////////////////////////////
  // generator bank sizing

  // generator index and bank size
  localparam int gen_idx_w = 3;
  localparam int num_gens  = 8;

  // tick count and period share one width
  localparam int period_w = 16;

  // spike token fields
  localparam int tag_w = 11;
  localparam int ct_w  = 10;

  // one state word per generator
  localparam int mem_w = 2 * period_w + tag_w;

  // memory word layout, tick count in the top bits
  typedef struct packed {
    logic [period_w-1:0] ticks;
    logic [period_w-1:0] period;
    logic [tag_w-1:0]    tag;
  } gen_word_t;

  //////////////////////////////////////////////////////////////////////
  // wishbone register map

  localparam int wb_adr_w = 4;
  localparam int wb_dat_w = 32;

  localparam logic [wb_adr_w-1:0] reg_ctrl        = 4'd0;
  localparam logic [wb_adr_w-1:0] reg_unit_len    = 4'd1;
  localparam logic [wb_adr_w-1:0] reg_gens_used   = 4'd2;
  localparam logic [wb_adr_w-1:0] reg_gens_en     = 4'd3;
  localparam logic [wb_adr_w-1:0] reg_prog_idx    = 4'd4;
  localparam logic [wb_adr_w-1:0] reg_prog_period = 4'd5;
  localparam logic [wb_adr_w-1:0] reg_prog_ticks  = 4'd6;
  localparam logic [wb_adr_w-1:0] reg_prog_tag_go = 4'd7;
  localparam logic [wb_adr_w-1:0] reg_status      = 4'd8;

  // clocks per time unit out of reset
  localparam int unit_len_reset = 64;

endpackage

//--- logic/tag_ct_channel.sv
`timescale 1ns/1ps

// spike token stream, valid/ready handshake
interface tag_ct_channel import spike_gen_pkg::*; ();

  // valid from the source, accept from the sink
  logic             v;
  logic             a;

  // destination tag and spike count
  logic [tag_w-1:0] tag;
  logic [ct_w-1:0]  ct;

  // update engine side
  modport source (
    output v, tag, ct,
    input  a
  );

  // consumer side
  modport sink (
    input  v, tag, ct,
    output a
  );

endinterface

//--- logic/spike_gen_prog_channel.sv
`timescale 1ns/1ps

// one generator word to be written into the state RAM
interface spike_gen_prog_channel import spike_gen_pkg::*; ();

  logic                 v;
  logic                 a;

  // target generator and its new state
  logic [gen_idx_w-1:0] gen_idx;
  logic [period_w-1:0]  period;
  logic [period_w-1:0]  ticks;
  logic [tag_w-1:0]     tag;

  // register block side
  modport source (
    output v, gen_idx, period, ticks, tag,
    input  a
  );

  // update engine side, a only while idle
  modport sink (
    input  v, gen_idx, period, ticks, tag,
    output a
  );

endinterface

//--- logic/spike_gen_mem.sv
`timescale 1ns/1ps

// generator state RAM, one write port and one read port
module spike_gen_mem import spike_gen_pkg::*; (
  input  logic                 clk,
  input  logic                 wr_en,
  input  logic [gen_idx_w-1:0] wr_addr,
  input  logic [mem_w-1:0]     wr_data,
  input  logic                 rd_en,
  input  logic [gen_idx_w-1:0] rd_addr,
  output logic [mem_w-1:0]     rd_data
);

  // storage array
  logic [mem_w-1:0] ram [num_gens];

  // first read stage inside the RAM
  logic [mem_w-1:0] rd_q;

  // synchronous write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      ram[wr_addr] <= wr_data;
    end
  end

  // read array stage, loaded only on rd_en
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_q <= ram[rd_addr];
    end
  end

  // output register, data lands two cycles after rd_en
  // and then holds as long as no new read is issued
  always_ff @(posedge clk) begin
    rd_data <= rd_q;
  end

endmodule

//--- logic/spike_gen_array.sv
`timescale 1ns/1ps

// update engine for the uniform spike generators
// walks the state RAM once per time unit, three cycles per enabled generator
module spike_gen_array import spike_gen_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  logic                unit_pulse,
  input  logic [gen_idx_w:0]  gens_used,
  input  logic [num_gens-1:0] gens_en,
  spike_gen_prog_channel.sink prog,
  tag_ct_channel.source       out,
  output logic                overrun
);

  typedef enum logic [1:0] {
    st_idle_prog,
    st_read,
    st_wait,
    st_write
  } state_t;

  state_t state;
  state_t state_nxt;

  // generator being updated
  logic [gen_idx_w-1:0] gen_idx;
  logic [gen_idx_w-1:0] idx_nxt;
  // one extra bit so the compare against gens_used never wraps
  logic [gen_idx_w:0]   gen_idx_p1;

  // an overrun pulse waiting for the current generator to finish
  logic restart_pend;
  logic restart;
  // current generator is done this cycle
  logic step_done;
  logic stall_out;
  logic prog_accept;

  // RAM ports
  logic                 mem_wr_en;
  logic [gen_idx_w-1:0] mem_wr_addr;
  logic [mem_w-1:0]     mem_wr_data;
  logic                 mem_rd_en;
  logic [mem_w-1:0]     mem_rd_data;

  // datapath
  gen_word_t           rd_word;
  gen_word_t           wb_word;
  logic [period_w-1:0] wr_ticks;
  logic                emit;

  spike_gen_mem u_mem (
    .clk     (clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_en   (mem_rd_en),
    .rd_addr (gen_idx),
    .rd_data (mem_rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // sequencing

  // the only adder on the index
  assign gen_idx_p1 = {1'b0, gen_idx} + 1'b1;

  // spike offered but not taken yet
  assign stall_out = out.v & ~out.a;

  // pulse while busy, still counts as the start of a new walk
  assign overrun = unit_pulse & (state != st_idle_prog);
  assign restart = unit_pulse | restart_pend;

  always_comb begin
    state_nxt = state;
    idx_nxt   = gen_idx;
    step_done = 1'b0;
    case (state)
      st_idle_prog: begin
        // zero generators in use means nothing to walk
        if (unit_pulse && gens_used != '0) begin
          state_nxt = st_read;
          idx_nxt   = '0;
        end
      end
      st_read: begin
        // disabled generators are skipped in one cycle
        if (gens_en[gen_idx]) begin
          state_nxt = st_wait;
        end else begin
          step_done = 1'b1;
        end
      end
      st_wait: begin
        state_nxt = st_write;
      end
      st_write: begin
        // hold here until the spike is taken
        if (!stall_out) begin
          step_done = 1'b1;
        end
      end
      default: begin
        state_nxt = st_idle_prog;
      end
    endcase

    // pick the next generator, or start over after an overrun
    if (step_done) begin
      if (restart && gens_used != '0) begin
        state_nxt = st_read;
        idx_nxt   = '0;
      end else if (gen_idx_p1 < gens_used) begin
        state_nxt = st_read;
        idx_nxt   = gen_idx_p1[gen_idx_w-1:0];
      end else begin
        state_nxt = st_idle_prog;
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= st_idle_prog;
      gen_idx      <= '0;
      restart_pend <= 1'b0;
    end else begin
      state   <= state_nxt;
      gen_idx <= idx_nxt;
      // a boundary consumes any pending restart
      if (step_done) begin
        restart_pend <= 1'b0;
      end else if (overrun) begin
        restart_pend <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // update rule

  // read word is valid from the output register in st_write
  assign rd_word = gen_word_t'(mem_rd_data);

  always_comb begin
    if (rd_word.ticks < rd_word.period) begin
      wr_ticks = rd_word.ticks + 1'b1;
      emit     = 1'b0;
    end else begin
      // wrap to one and fire
      wr_ticks = period_w'(1);
      emit     = 1'b1;
    end
  end

  // only the tick count changes on writeback
  assign wb_word.ticks  = wr_ticks;
  assign wb_word.period = rd_word.period;
  assign wb_word.tag    = rd_word.tag;

  //////////////////////////////////////////////////////////////////////
  // RAM control

  // programming words go in only while idle
  assign prog_accept = prog.v & (state == st_idle_prog);
  assign prog.a      = prog_accept;

  assign mem_rd_en   = (state == st_read) & gens_en[gen_idx];
  assign mem_wr_en   = (state == st_write) | prog_accept;
  assign mem_wr_addr = prog_accept ? prog.gen_idx : gen_idx;
  assign mem_wr_data = prog_accept ? {prog.ticks, prog.period, prog.tag} : wb_word;

  //////////////////////////////////////////////////////////////////////
  // spike output

  // the RAM output holds through a stall, so tag stays put
  assign out.v   = (state == st_write) & emit;
  assign out.tag = rd_word.tag;
  assign out.ct  = ct_w'(1);

endmodule

//--- logic/spike_gen_ctrl.sv
`timescale 1ns/1ps

// wishbone classic register block, time unit timer and programming launcher
module spike_gen_ctrl import spike_gen_pkg::*; (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [wb_adr_w-1:0]                wb_adr,
  input  logic [spike_gen_pkg::wb_dat_w-1:0] wb_dat_w,
  output logic [spike_gen_pkg::wb_dat_w-1:0] wb_dat_r,
  output logic                               wb_ack,
  spike_gen_prog_channel.source              prog,
  output logic [gen_idx_w:0]                 gens_used,
  output logic [num_gens-1:0]                gens_en,
  output logic                               unit_pulse,
  input  logic                               overrun
);

  // register file
  logic                               run;
  logic [spike_gen_pkg::wb_dat_w-1:0] unit_len;
  logic [gen_idx_w-1:0]               prog_idx;
  logic [period_w-1:0]                prog_period;
  logic [period_w-1:0]                prog_ticks;
  logic [tag_w-1:0]                   prog_tag;
  logic                               overrun_seen;

  // timer
  logic [spike_gen_pkg::wb_dat_w-1:0] unit_cnt;
  logic                               run_set;

  // bus decode
  logic wb_req;
  logic wr_en;
  logic go_wr;
  logic prog_v;

  //////////////////////////////////////////////////////////////////////
  // bus decode and ack

  // new access, ack not given yet
  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign wr_en  = wb_req & wb_we;
  // launch write waits for the engine before it is acked
  assign go_wr  = wr_en & (wb_adr == reg_prog_tag_go);
  // any write of the run bit restarts the unit count
  assign run_set = wr_en & (wb_adr == reg_ctrl) & wb_dat_w[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_ack <= 1'b0;
      prog_v <= 1'b0;
    end else begin
      // plain registers ack next cycle, launch acks after accept
      wb_ack <= (wb_req & ~go_wr) | (prog_v & prog.a);
      if (go_wr && !prog_v) begin
        prog_v <= 1'b1;
      end else if (prog_v && prog.a) begin
        prog_v <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // register writes

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      run         <= 1'b0;
      unit_len    <= unit_len_reset;
      gens_used   <= '0;
      gens_en     <= '0;
      prog_idx    <= '0;
      prog_period <= '0;
      prog_ticks  <= '0;
      prog_tag    <= '0;
    end else if (wr_en) begin
      case (wb_adr)
        reg_ctrl:        run <= wb_dat_w[0];
        reg_unit_len:    unit_len <= wb_dat_w;
        // clamp to the bank size
        reg_gens_used: begin
          if (wb_dat_w > num_gens) begin
            gens_used <= (gen_idx_w + 1)'(num_gens);
          end else begin
            gens_used <= wb_dat_w[gen_idx_w:0];
          end
        end
        reg_gens_en:     gens_en <= wb_dat_w[num_gens-1:0];
        reg_prog_idx:    prog_idx <= wb_dat_w[gen_idx_w-1:0];
        reg_prog_period: prog_period <= wb_dat_w[period_w-1:0];
        reg_prog_ticks:  prog_ticks <= wb_dat_w[period_w-1:0];
        // tag captured once, stays put while the request is pending
        reg_prog_tag_go: begin
          if (!prog_v) begin
            prog_tag <= wb_dat_w[tag_w-1:0];
          end
        end
        default: ;
      endcase
    end
  end

  // sticky overrun, write one clears, a new pulse wins
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      overrun_seen <= 1'b0;
    end else if (overrun) begin
      overrun_seen <= 1'b1;
    end else if (wr_en && wb_adr == reg_status && wb_dat_w[0]) begin
      overrun_seen <= 1'b0;
    end
  end

  // read mux, data valid alongside ack
  always_comb begin
    wb_dat_r = '0;
    case (wb_adr)
      reg_ctrl:        wb_dat_r[0] = run;
      reg_unit_len:    wb_dat_r = unit_len;
      reg_gens_used:   wb_dat_r[gen_idx_w:0] = gens_used;
      reg_gens_en:     wb_dat_r[num_gens-1:0] = gens_en;
      reg_prog_idx:    wb_dat_r[gen_idx_w-1:0] = prog_idx;
      reg_prog_period: wb_dat_r[period_w-1:0] = prog_period;
      reg_prog_ticks:  wb_dat_r[period_w-1:0] = prog_ticks;
      reg_prog_tag_go: wb_dat_r[tag_w-1:0] = prog_tag;
      reg_status:      wb_dat_r[0] = overrun_seen;
      default:         wb_dat_r = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // time unit timer

  // first pulse lands unit_len clocks after the run write
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      unit_cnt   <= '0;
      unit_pulse <= 1'b0;
    end else if (run_set || !run) begin
      unit_cnt   <= '0;
      unit_pulse <= 1'b0;
    end else if (unit_cnt == unit_len - 1'b1) begin
      unit_cnt   <= '0;
      unit_pulse <= 1'b1;
    end else begin
      unit_cnt   <= unit_cnt + 1'b1;
      unit_pulse <= 1'b0;
    end
  end

  // programming request
  assign prog.v       = prog_v;
  assign prog.gen_idx = prog_idx;
  assign prog.period  = prog_period;
  assign prog.ticks   = prog_ticks;
  assign prog.tag     = prog_tag;

endmodule

//--- logic/spike_gen_top.sv
`timescale 1ns/1ps

// spike generator subsystem, wishbone slave in and spike stream out
module spike_gen_top import spike_gen_pkg::*; (
  input  logic                               clk,
  input  logic                               reset,
  // wishbone classic slave
  input  logic                               wb_cyc,
  input  logic                               wb_stb,
  input  logic                               wb_we,
  input  logic [wb_adr_w-1:0]                wb_adr,
  input  logic [spike_gen_pkg::wb_dat_w-1:0] wb_dat_w,
  output logic [spike_gen_pkg::wb_dat_w-1:0] wb_dat_r,
  output logic                               wb_ack,
  // spike stream
  output logic                               spike_valid,
  input  logic                               spike_ready,
  output logic [tag_w-1:0]                   spike_tag,
  output logic [ct_w-1:0]                    spike_ct,
  // start of each time unit
  output logic                               time_unit
);

  tag_ct_channel         spikes ();
  spike_gen_prog_channel prog_ch ();

  logic [gen_idx_w:0]  gens_used;
  logic [num_gens-1:0] gens_en;
  logic                unit_pulse;
  logic                overrun;

  spike_gen_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .prog       (prog_ch.source),
    .gens_used  (gens_used),
    .gens_en    (gens_en),
    .unit_pulse (unit_pulse),
    .overrun    (overrun)
  );

  spike_gen_array u_array (
    .clk        (clk),
    .reset      (reset),
    .unit_pulse (unit_pulse),
    .gens_used  (gens_used),
    .gens_en    (gens_en),
    .prog       (prog_ch.sink),
    .out        (spikes.source),
    .overrun    (overrun)
  );

  // stream sink side maps onto the plain ports
  assign spikes.a    = spike_ready;
  assign spike_valid = spikes.v;
  assign spike_tag   = spikes.tag;
  assign spike_ct    = spikes.ct;

  assign time_unit = unit_pulse;

endmodule

//--- dv/spike_gen_tb.sv
`timescale 1ns/1ps

// directed testbench for the spike generator subsystem
module spike_gen_tb import spike_gen_pkg::*; ();

  // tests take about 23k cycles, most of it the 200 back-pressure units
  localparam int          max_cycles = 40000;
  localparam logic [15:0] lfsr_seed  = 16'd41;

  logic                               clk;
  logic                               reset;
  logic                               wb_cyc;
  logic                               wb_stb;
  logic                               wb_we;
  logic [wb_adr_w-1:0]                wb_adr;
  logic [spike_gen_pkg::wb_dat_w-1:0] wb_dat_w;
  logic [spike_gen_pkg::wb_dat_w-1:0] wb_dat_r;
  logic                               wb_ack;
  logic                               spike_valid;
  logic                               spike_ready;
  logic [tag_w-1:0]                   spike_tag;
  logic [ct_w-1:0]                    spike_ct;
  logic                               time_unit;

  // reference model, one entry per generator
  logic [period_w-1:0] m_tick   [num_gens];
  logic [period_w-1:0] m_period [num_gens];
  logic [tag_w-1:0]    m_tag    [num_gens];
  int                  m_used;
  logic [num_gens-1:0] m_en;
  // tags still owed by the DUT, oldest first
  logic [tag_w-1:0]    exp_q [$];
  logic [tag_w-1:0]    exp_tag;

  logic        check_on;
  logic        rand_ready;
  logic [15:0] lfsr;
  int          cycles;
  int          errors;
  int          checks;
  // negedges from request to ack of the last bus access
  int          ack_wait;
  // clocks per time unit last programmed, and the cycle of the last unit start
  int          unit_len_exp;
  int          unit_mark;

  spike_gen_top DUT (
    .clk         (clk),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .spike_valid (spike_valid),
    .spike_ready (spike_ready),
    .spike_tag   (spike_tag),
    .spike_ct    (spike_ct),
    .time_unit   (time_unit)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // stimulus sources and watchdog

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;
    end
    return n;
  endfunction

  // one step per ready bit, on the falling edge
  always @(negedge clk) begin
    if (rand_ready) begin
      lfsr        = lfsr_next(lfsr);
      spike_ready = lfsr[0];
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d cycles", max_cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and spike monitor

  // time_unit is stable at the falling edge
  always @(negedge clk) begin
    if (!reset && time_unit && check_on) begin
      // same walk order as the engine, ascending index
      for (int g = 0; g < num_gens; g++) begin
        if (g < m_used && m_en[g]) begin
          if (m_tick[g] < m_period[g]) begin
            m_tick[g] = m_tick[g] + 1'b1;
          end else begin
            m_tick[g] = 1;
            exp_q.push_back(m_tag[g]);
          end
        end
      end
    end
  end

  // one pulse every unit_len clocks, the first unit_len clocks after the run write
  always @(negedge clk) begin
    if (!reset && time_unit) begin
      checks = checks + 1;
      if (cycles - unit_mark != unit_len_exp) begin
        errors = errors + 1;
        $display("Error at %0t: time_unit spacing = %0d, expected %0d", $time,
                 cycles - unit_mark, unit_len_exp);
      end
      unit_mark = cycles;
    end
  end

  // a transfer is a rising edge with valid and ready both high
  always @(posedge clk) begin
    if (!reset && check_on && spike_valid && spike_ready) begin
      checks = checks + 1;
      if (exp_q.size() == 0) begin
        errors = errors + 1;
        $display("unexpected spike with tag %0h at %0t, none was due", spike_tag, $time);
      end else begin
        exp_tag = exp_q.pop_front();
        if (spike_tag !== exp_tag) begin
          errors = errors + 1;
          $display("Error at %0t: spike_tag = %0h, expected %0h", $time, spike_tag, exp_tag);
        end
      end
      if (spike_ct !== ct_w'(1)) begin
        errors = errors + 1;
        $display("Error at %0t: spike_ct = %0d, expected 1", $time, spike_ct);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus and sequencing helpers

  task automatic wait_ack();
    ack_wait = 1;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
      ack_wait = ack_wait + 1;
    end
  endtask

  task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [31:0] data);
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    wait_ack();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [31:0] data);
    @(negedge clk);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    // read mux follows wb_adr, still held here
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // plain registers also ack after exactly one cycle
  task automatic check_reg(input logic [wb_adr_w-1:0] adr, input string name,
                           input logic [31:0] exp);
    logic [31:0] val;
    wb_read(adr, val);
    checks = checks + 1;
    if (val !== exp) begin
      errors = errors + 1;
      $display("Error at %0t: %s = %0h, expected %0h", $time, name, val, exp);
    end
    if (ack_wait != 1) begin
      errors = errors + 1;
      $display("wb_ack for %s came after %0d cycles instead of one", name, ack_wait);
    end
  endtask

  task automatic program_gen(input logic [gen_idx_w-1:0] idx, input logic [period_w-1:0] period,
                             input logic [period_w-1:0] ticks, input logic [tag_w-1:0] tag);
    wb_write(reg_prog_idx, idx);
    wb_write(reg_prog_period, period);
    wb_write(reg_prog_ticks, ticks);
    wb_write(reg_prog_tag_go, tag);
    m_tick[idx]   = ticks;
    m_period[idx] = period;
    m_tag[idx]    = tag;
  endtask

  task automatic set_gens(input int used, input logic [num_gens-1:0] en);
    wb_write(reg_gens_used, used);
    wb_write(reg_gens_en, en);
    m_used = used;
    m_en   = en;
  endtask

  task automatic start_timer(input int len);
    wb_write(reg_unit_len, len);
    wb_write(reg_ctrl, 32'd1);
    // the run write landed on the rising edge just before this falling edge
    unit_len_exp = len;
    unit_mark    = cycles;
  endtask

  task automatic wait_unit();
    @(negedge clk);
    while (!time_unit) begin
      @(negedge clk);
    end
  endtask

  task automatic run_units(input int n);
    repeat (n) wait_unit();
  endtask

  // timer must be stopped first, then every owed spike has to show up
  task automatic drain_spikes(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n = n + 1;
    end
    repeat (10) @(negedge clk);
    checks = checks + 1;
    if (exp_q.size() != 0) begin
      errors = errors + 1;
      $display("%0d expected spikes never arrived by %0t", exp_q.size(), $time);
      exp_q.delete();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests

  task automatic test_registers();
    check_reg(reg_ctrl, "ctrl", 0);
    check_reg(reg_unit_len, "unit_len", unit_len_reset);
    check_reg(reg_gens_used, "gens_used", 0);
    check_reg(reg_gens_en, "gens_en", 0);
    check_reg(reg_prog_idx, "prog_idx", 0);
    check_reg(reg_prog_period, "prog_period", 0);
    check_reg(reg_prog_ticks, "prog_ticks", 0);
    check_reg(reg_prog_tag_go, "prog_tag", 0);
    check_reg(reg_status, "status", 0);
    wb_write(reg_unit_len, 32'd123);
    wb_write(reg_gens_used, 32'd5);
    wb_write(reg_gens_en, 32'ha5);
    check_reg(reg_unit_len, "unit_len", 123);
    check_reg(reg_gens_used, "gens_used", 5);
    check_reg(reg_gens_en, "gens_en", 32'ha5);
  endtask

  // gen 0 fires first in unit 3, gen 1 first in unit 3 as well
  task automatic test_schedule();
    program_gen(0, 2, 0, 11'h123);
    program_gen(1, 4, 2, 11'h456);
    set_gens(2, 8'h03);
    start_timer(40);
    run_units(20);
    wb_write(reg_ctrl, 0);
    drain_spikes(200);
    check_reg(reg_status, "status", 0);
  endtask

  task automatic test_back_pressure();
    // switch away from the falling edge so the lfsr sequence is fixed
    @(posedge clk);
    rand_ready = 1'b1;
    start_timer(100);
    run_units(200);
    wb_write(reg_ctrl, 0);
    drain_spikes(500);
    @(posedge clk);
    rand_ready = 1'b0;
    @(negedge clk);
    spike_ready = 1'b1;
    check_reg(reg_status, "status", 0);
  endtask

  // mask changes land mid unit, long after the short walk ends
  task automatic test_enable_mask();
    start_timer(40);
    run_units(5);
    repeat (20) @(negedge clk);
    set_gens(2, 8'h02);
    run_units(5);
    repeat (20) @(negedge clk);
    set_gens(2, 8'h03);
    run_units(10);
    wb_write(reg_ctrl, 0);
    drain_spikes(200);
    check_reg(reg_status, "status", 0);
  endtask

  // a full walk needs 24 cycles, far more than a 10 cycle unit
  task automatic test_overrun();
    for (int g = 2; g < num_gens; g++) begin
      program_gen(g, 3, 0, tag_w'(16 + g));
    end
    // spikes may be skipped, so the model sits this one out
    check_on = 1'b0;
    set_gens(8, 8'hff);
    start_timer(10);
    run_units(6);
    wb_write(reg_ctrl, 0);
    repeat (100) @(negedge clk);
    check_reg(reg_status, "status", 1);
    wb_write(reg_status, 32'd1);
    check_reg(reg_status, "status", 0);
    exp_q.delete();
    check_on = 1'b1;
  endtask

  task automatic test_prog_during_update();
    program_gen(0, 2, 0, 11'h123);
    program_gen(1, 4, 2, 11'h456);
    set_gens(2, 8'h03);
    start_timer(40);
    run_units(3);
    // staged word for gen 1, launch comes later
    wb_write(reg_prog_idx, 32'd1);
    wb_write(reg_prog_period, 32'd3);
    wb_write(reg_prog_ticks, 32'd0);
    wait_unit();
    wb_write(reg_prog_tag_go, 32'h2a5);
    checks = checks + 1;
    // an idle engine takes the launch in two cycles
    if (ack_wait <= 2) begin
      errors = errors + 1;
      $display("launch during an update was acked after %0d cycles without waiting",
               ack_wait);
    end
    m_tick[1]   = 0;
    m_period[1] = 3;
    m_tag[1]    = 11'h2a5;
    run_units(10);
    wb_write(reg_ctrl, 0);
    drain_spikes(200);
    check_reg(reg_status, "status", 0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    spike_ready  = 1'b1;
    rand_ready   = 1'b0;
    check_on     = 1'b1;
    lfsr         = lfsr_seed;
    cycles       = 0;
    errors       = 0;
    checks       = 0;
    ack_wait     = 0;
    unit_len_exp = unit_len_reset;
    unit_mark    = 0;
    m_used       = 0;
    m_en         = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    test_registers();
    test_schedule();
    test_back_pressure();
    test_enable_mask();
    test_overrun();
    test_prog_during_update();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/spike_gen_pkg.sv
logic/tag_ct_channel.sv
logic/spike_gen_prog_channel.sv
logic/spike_gen_mem.sv
logic/spike_gen_array.sv
logic/spike_gen_ctrl.sv
logic/spike_gen_top.sv
dv/spike_gen_tb.sv
